// ==== list.f ====
rtl/desc_pkg.sv
rtl/bram_simple2port.sv
rtl/prefetch_rb.sv
rtl/desc_builder.sv
rtl/desc_dispatch.sv
rtl/desc_queue_top.sv
tb/desc_queue_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the descriptor queue testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert -Wno-fatal \
    --top-module desc_queue_tb \
    -f list.f \
    -o desc_queue_sim

./obj_dir/desc_queue_sim | tee sim.log

if grep -q "Regression passed" sim.log; then
    echo "simulation run: PASS"
    exit 0
else
    echo "simulation run: FAIL"
    exit 1
fi

// ==== tb/desc_queue_tb.sv ====
`timescale 1ns/1ps

module desc_queue_tb;
    import desc_pkg::*;

    localparam int DEPTH = 16;
    // the five tests run for about 800 cycles, the rest is margin
    localparam int TIMEOUT_CYCLES = 20000;
    // a full queue empties in under DEPTH cycles with the sink ready
    localparam int DRAIN_LIMIT = 4 * DEPTH;

    logic        clk;
    logic        rst_r;
    logic        pkt_strobe;
    pkt_addr_t   pkt_addr;
    pkt_len_t    pkt_len;
    logic        sink_ready;
    logic        desc_valid;
    pkt_desc_t   desc;
    byte_total_t byte_total;
    logic        drop_pulse;
    logic [15:0] drop_count;

    logic [31:0] lfsr_state = 32'h57fd4fd5;
    int          check_count = 0;
    int          error_count = 0;
    int          err_mark = 0;
    int          cycle_count = 0;

    // reference model state
    pkt_desc_t   exp_q [$];
    int          m_cnt;        // entries held by the ring buffer
    logic        m_wr;         // write in flight to the ring buffer
    logic        exp_valid;
    logic        exp_drop;
    pkt_seq_t    m_seq;
    byte_total_t m_total;
    logic [15:0] m_drops;
    int          accepted = 0;
    int          dropped = 0;
    int          delivered = 0;  // desc_valid pulses seen on the DUT

    desc_queue_top #(
        .DEPTH (DEPTH)
    ) desc_queue_top_i (
        .clk        (clk),
        .rst_r      (rst_r),
        .pkt_strobe (pkt_strobe),
        .pkt_addr   (pkt_addr),
        .pkt_len    (pkt_len),
        .sink_ready (sink_ready),
        .desc_valid (desc_valid),
        .desc       (desc),
        .byte_total (byte_total),
        .drop_pulse (drop_pulse),
        .drop_count (drop_count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    // expected descriptor for an accepted strobe
    function automatic pkt_desc_t make_desc(input pkt_seq_t seq, input pkt_addr_t addr,
                                            input pkt_len_t len);
        pkt_desc_t d;
        d.seq  = seq;
        d.addr = addr;
        d.len  = len;
        return d;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic tick(input logic strobe, input pkt_addr_t addr, input pkt_len_t len,
                        input logic ready);
        @(posedge clk);
        #2;
        pkt_strobe = strobe;
        pkt_addr   = addr;
        pkt_len    = len;
        sink_ready = ready;
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            error_count++;
            $display("queue still held %0d descriptors after %0d cycles",
                     exp_q.size(), DRAIN_LIMIT);
        end
        repeat (4) @(negedge clk);
    endtask

    task automatic finish_test(input int num, input string name);
        $display("test %0d %s: %0d errors", num, name, error_count - err_mark);
        err_mark = error_count;
    endtask

    // compare process, outputs first, then step the model with this cycle's inputs
    always @(negedge clk) begin
        pkt_desc_t d;
        logic      m_rd;
        logic      m_acc;
        if (rst_r) begin
            exp_q.delete();
            m_cnt     = 0;
            m_wr      = 1'b0;
            exp_valid = 1'b0;
            exp_drop  = 1'b0;
            m_seq     = '0;
            m_total   = '0;
            m_drops   = '0;
        end else begin
            check_value("desc_valid", 64'(desc_valid), 64'(exp_valid));
            check_value("drop_pulse", 64'(drop_pulse), 64'(exp_drop));
            check_value("drop_count", 64'(drop_count), 64'(m_drops));
            if (desc_valid) begin
                delivered++;
            end
            if (desc_valid && exp_q.size() == 0) begin
                error_count++;
                $display("desc_valid came while no descriptor was expected");
            end else if (desc_valid) begin
                d = exp_q.pop_front();
                m_total = m_total + byte_total_t'(d.len);
                check_value("desc", 64'(desc), 64'(d));
                check_value("byte_total", 64'(byte_total), 64'(m_total));
            end

            m_rd  = sink_ready && m_cnt != 0;
            m_acc = pkt_strobe && (m_cnt - int'(m_rd)) < DEPTH - 2;
            m_cnt = m_cnt + int'(m_wr) - int'(m_rd);
            m_wr  = m_acc;
            exp_valid = m_rd;
            exp_drop  = pkt_strobe && !m_acc;
            if (m_acc) begin
                exp_q.push_back(make_desc(m_seq, pkt_addr, pkt_len));
                m_seq = m_seq + 16'd1;
                accepted++;
            end
            if (exp_drop) begin
                dropped++;
                if (m_drops != '1) begin
                    m_drops = m_drops + 16'd1;
                end
            end
        end
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Regression failed");
        $finish;
    end

    initial begin
        int lat;
        int n;
        int run;
        int acc0;
        int drp0;
        int del0;
        int sent;
        int dut_acc;
        logic [15:0] dc0;
        rst_r      = 1'b1;
        pkt_strobe = 1'b0;
        pkt_addr   = '0;
        pkt_len    = '0;
        sink_ready = 1'b0;
        repeat (10) @(posedge clk);
        #2;
        rst_r = 1'b0;

        // test 1: quiet after reset
        @(negedge clk);
        check_value("desc_valid", 64'(desc_valid), 64'd0);
        check_value("drop_pulse", 64'(drop_pulse), 64'd0);
        check_value("drop_count", 64'(drop_count), 64'd0);
        check_value("byte_total", 64'(byte_total), 64'd0);
        repeat (20) tick(1'b0, '0, '0, 1'b1);
        @(negedge clk);
        check_value("delivered after idle", 64'(delivered), 64'd0);
        finish_test(1, "reset and idle");

        // test 2: single packets, sink ready
        for (int i = 0; i < 6; i++) begin
            tick(1'b1, rand_bits(32), 16'(rand_bits(16)), 1'b1);
            tick(1'b0, '0, '0, 1'b1);
            lat = 0;
            do begin
                @(negedge clk);
                lat++;
            end while (!desc_valid && lat < 10);
            check_value("dispatch latency", 64'(lat), 64'd3);
            repeat (3) tick(1'b0, '0, '0, 1'b1);
        end
        wait_drained();
        check_value("delivered singles", 64'(delivered), 64'd6);
        finish_test(2, "single packets");

        // test 3: bursts with random sink_ready
        for (int i = 0; i < 400; i++) begin
            if (i < 200) begin
                tick(rand_bits(3) != '0, rand_bits(32), 16'(rand_bits(16)), rand_bits(1) != '0);
            end else begin
                tick(rand_bits(1) != '0, rand_bits(32), 16'(rand_bits(16)), rand_bits(2) != '0);
            end
        end
        tick(1'b0, '0, '0, 1'b1);
        wait_drained();
        check_value("delivered count", 64'(delivered), 64'(accepted));
        check_value("byte_total after burst", 64'(byte_total), 64'(m_total));
        finish_test(3, "random bursts");

        // test 4: overflow with sink held off
        acc0 = accepted;
        drp0 = dropped;
        dc0  = drop_count;
        sent = DEPTH + 8;
        for (int i = 0; i < sent; i++) begin
            tick(1'b1, rand_bits(32), 16'(rand_bits(16)), 1'b0);
        end
        repeat (3) tick(1'b0, '0, '0, 1'b0);
        @(negedge clk);
        dut_acc = sent - int'(drop_count - dc0);
        check_value("accepted plus dropped", 64'((accepted - acc0) + int'(drop_count - dc0)),
                    64'(sent));
        check_value("accepted in range",
                    64'(dut_acc >= DEPTH - 3 && dut_acc <= DEPTH - 1), 64'd1);
        check_value("drop_count growth", 64'(drop_count - dc0), 64'(dropped - drp0));
        finish_test(4, "overflow");

        // test 5: drain back to back, then accept again
        n = exp_q.size();
        tick(1'b0, '0, '0, 1'b1);
        do begin
            @(negedge clk);
        end while (!desc_valid);
        run = 0;
        while (desc_valid) begin
            run++;
            @(negedge clk);
        end
        check_value("drain run length", 64'(run), 64'(n));
        del0 = delivered;
        dc0  = drop_count;
        for (int i = 0; i < 8; i++) begin
            tick(1'b1, rand_bits(32), 16'(rand_bits(16)), 1'b1);
            repeat (rand_bits(2)) tick(1'b0, '0, '0, 1'b1);
        end
        tick(1'b0, '0, '0, 1'b1);
        wait_drained();
        check_value("delivered after drain", 64'(delivered - del0), 64'd8);
        check_value("drops after drain", 64'(drop_count - dc0), 64'd0);
        check_value("delivered total", 64'(delivered), 64'(accepted));
        finish_test(5, "drain and resume");

        $display("summary: 5 tests, %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== rtl/desc_queue_top.sv ====
`timescale 1ns/1ps

// packet descriptor queue
// builder -> prefetching ring buffer -> dispatcher
module desc_queue_top #(
    parameter int DEPTH = desc_pkg::DESC_DEPTH_DEFAULT
) (
    input  logic                  clk,
    input  logic                  rst_r,
    input  logic                  pkt_strobe,
    input  desc_pkg::pkt_addr_t   pkt_addr,
    input  desc_pkg::pkt_len_t    pkt_len,
    input  logic                  sink_ready,
    output logic                  desc_valid,
    output desc_pkg::pkt_desc_t   desc,
    output desc_pkg::byte_total_t byte_total,
    output logic                  drop_pulse,
    output logic [15:0]           drop_count
);
    import desc_pkg::*;

    logic                     wr_en;
    pkt_desc_t                wr_data;
    logic [$clog2(DEPTH)-1:0] occup;    // fill level seen by the builder
    logic                     rd_en;
    pkt_desc_t                rd_data;  // head entry
    logic                     avail;

    desc_builder #(
        .DEPTH (DEPTH)
    ) desc_builder_i (
        .clk        (clk),
        .rst_r      (rst_r),
        .pkt_strobe (pkt_strobe),
        .pkt_addr   (pkt_addr),
        .pkt_len    (pkt_len),
        .occup      (occup),
        .wr_en      (wr_en),
        .wr_data    (wr_data),
        .drop_pulse (drop_pulse),
        .drop_count (drop_count)
    );

    prefetch_rb #(
        .DEPTH (DEPTH)
    ) prefetch_rb_i (
        .clk     (clk),
        .rst_r   (rst_r),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_data (rd_data),
        .avail   (avail),
        .occup   (occup)
    );

    desc_dispatch desc_dispatch_i (
        .clk        (clk),
        .rst_r      (rst_r),
        .sink_ready (sink_ready),
        .avail      (avail),
        .rd_data    (rd_data),
        .rd_en      (rd_en),
        .desc_valid (desc_valid),
        .desc       (desc),
        .byte_total (byte_total)
    );

endmodule

// ==== rtl/desc_dispatch.sv ====
`timescale 1ns/1ps

// hands queued descriptors to the downstream engine
// pops whenever the engine holds ready and an entry is waiting, then
// presents the descriptor with a one-cycle valid in the next cycle
module desc_dispatch (
    input  logic                    clk,
    input  logic                    rst_r,
    input  logic                    sink_ready,
    input  logic                    avail,
    input  desc_pkg::pkt_desc_t     rd_data,
    output logic                    rd_en,
    output logic                    desc_valid,
    output desc_pkg::pkt_desc_t     desc,
    output desc_pkg::byte_total_t   byte_total
);
    import desc_pkg::*;

    byte_total_t pop_len;  // length of the entry popped this cycle

    // one pop per cycle while both levels are high
    assign rd_en   = sink_ready && avail;
    assign pop_len = byte_total_t'(rd_data.len);

    always_ff @(posedge clk) begin
        if (rst_r) begin
            desc_valid <= 1'b0;
            byte_total <= '0;
        end else begin
            desc_valid <= rd_en;
            if (rd_en) begin
                byte_total <= byte_total + pop_len;  // wraps
            end
        end
    end

    // descriptor payload, only meaningful with desc_valid
    always_ff @(posedge clk) begin
        if (rd_en) begin
            desc <= rd_data;
        end
    end

endmodule

// ==== rtl/desc_builder.sv ====
`timescale 1ns/1ps

// turns packet strobes into numbered descriptors for the ring buffer
// packets that arrive while the queue is nearly full are dropped and counted
module desc_builder #(
    parameter int DEPTH = desc_pkg::DESC_DEPTH_DEFAULT
) (
    input  logic                     clk,
    input  logic                     rst_r,
    input  logic                     pkt_strobe,
    input  desc_pkg::pkt_addr_t      pkt_addr,
    input  desc_pkg::pkt_len_t       pkt_len,
    input  logic [$clog2(DEPTH)-1:0] occup,
    output logic                     wr_en,
    output desc_pkg::pkt_desc_t      wr_data,
    output logic                     drop_pulse,
    output logic [15:0]              drop_count
);
    import desc_pkg::*;

    localparam int AW = $clog2(DEPTH);

    // occup lags a write by one cycle, so stop two short of the last slot
    localparam logic [AW-1:0] WR_LIMIT = AW'(DEPTH - 2);

    pkt_seq_t seq;     // number given to the next accepted packet
    logic     room;
    logic     accept;
    logic     drop;

    assign room   = occup < WR_LIMIT;
    assign accept = pkt_strobe && room;
    assign drop   = pkt_strobe && !room;

    always_ff @(posedge clk) begin
        if (rst_r) begin
            wr_en      <= 1'b0;
            drop_pulse <= 1'b0;
            drop_count <= '0;
            seq        <= '0;
        end else begin
            wr_en      <= accept;
            drop_pulse <= drop;
            if (accept) begin
                seq <= seq + 1'b1;  // wraps, drops leave no gap
            end
            if (drop && drop_count != '1) begin
                drop_count <= drop_count + 1'b1;  // saturates
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wr_data <= '{seq: seq, addr: pkt_addr, len: pkt_len};
        end
    end

endmodule

// ==== rtl/prefetch_rb.sv ====
`timescale 1ns/1ps

// descriptor ring buffer with bulk storage in block RAM
// the oldest five entries live in a register chain, so the head entry is
// always on rd_data without waiting for the RAM
// writes show up in avail and occup one cycle later, reads act at once
module prefetch_rb #(
    parameter int DEPTH = desc_pkg::DESC_DEPTH_DEFAULT
) (
    input  logic                     clk,
    input  logic                     rst_r,
    input  logic                     wr_en,
    input  desc_pkg::pkt_desc_t      wr_data,
    input  logic                     rd_en,
    output desc_pkg::pkt_desc_t      rd_data,
    output logic                     avail,
    output logic [$clog2(DEPTH)-1:0] occup
);
    import desc_pkg::*;

    localparam int AW      = $clog2(DEPTH);
    localparam int NB_PREF = 5;
    localparam int HEAD    = NB_PREF - 1;

    typedef logic [AW-1:0] rb_ptr_t;

    if ((1 << AW) != DEPTH || DEPTH < 16) begin : g_depth_check
        $error("prefetch_rb: DEPTH must be a power of two and at least 16");
    end

    rb_ptr_t   head;        // advances on write
    rb_ptr_t   tail;        // advances on read
    rb_ptr_t   real_occup;
    rb_ptr_t   tail_next;

    // pref[HEAD] holds the entry at tail, pref[HEAD-k] the entry at tail+k
    pkt_desc_t pref [NB_PREF];

    rb_ptr_t   ram_wr_addr;
    pkt_desc_t ram_wr_data;
    logic      ram_wren;
    rb_ptr_t   ram_rd_addr;
    logic      ram_rden;
    pkt_desc_t ram_q;

    // track each prefetch until its data is on ram_q
    logic      pf_vld_d1;
    logic      pf_vld_d2;
    rb_ptr_t   pf_addr_d1;
    rb_ptr_t   pf_addr_d2;
    rb_ptr_t   pf_dist;     // distance of returning entry from the new tail

    logic      wr_bypass;   // write lands straight in the register chain
    logic [2:0] wr_slot;
    logic [2:0] pf_slot;

    assign real_occup = head - tail;
    assign avail      = real_occup != '0;
    assign occup      = real_occup - rb_ptr_t'(rd_en);  // a read frees its slot now
    assign tail_next  = tail + rb_ptr_t'(rd_en);
    assign rd_data    = pref[HEAD];

    // slot positions are taken relative to the tail after this edge
    assign wr_bypass = occup < rb_ptr_t'(NB_PREF);
    assign wr_slot   = 3'(HEAD) - 3'(occup);
    assign pf_dist   = pf_addr_d2 - tail_next;
    assign pf_slot   = 3'(HEAD) - 3'(pf_dist);

    always_ff @(posedge clk) begin
        if (rst_r) begin
            head      <= '0;
            tail      <= '0;
            ram_wren  <= 1'b0;
            ram_rden  <= 1'b0;
            pf_vld_d1 <= 1'b0;
            pf_vld_d2 <= 1'b0;
        end else begin
            ram_wren  <= wr_en && !wr_bypass;
            // the entry five ahead moves into reach of the chain on this read
            ram_rden  <= rd_en && real_occup > rb_ptr_t'(NB_PREF);
            pf_vld_d1 <= ram_rden;
            pf_vld_d2 <= pf_vld_d1;
            if (wr_en) begin
                head <= head + 1'b1;
            end
            tail <= tail_next;
        end
    end

    always_ff @(posedge clk) begin
        ram_wr_addr <= head;
        ram_wr_data <= wr_data;
        ram_rd_addr <= tail + rb_ptr_t'(NB_PREF);
        pf_addr_d1  <= ram_rd_addr;
        pf_addr_d2  <= pf_addr_d1;

        if (rd_en) begin
            for (int i = 0; i < HEAD; i++) begin
                pref[i+1] <= pref[i];  // shift toward the head
            end
        end

        // returning prefetch, at least one read ahead of being needed
        if (pf_vld_d2) begin
            pref[pf_slot] <= ram_q;
        end

        if (wr_en && wr_bypass) begin
            pref[wr_slot] <= wr_data;
        end
    end

    bram_simple2port #(
        .DEPTH (DEPTH)
    ) desc_ram_i (
        .clk     (clk),
        .wr_addr (ram_wr_addr),
        .wr_data (ram_wr_data),
        .wren    (ram_wren),
        .rd_addr (ram_rd_addr),
        .rden    (ram_rden),
        .q       (ram_q)
    );

    // the dispatcher gates rd_en with avail
    a_rd_when_avail: assert property (@(posedge clk) disable iff (rst_r)
        rd_en |-> avail)
        else $error("prefetch_rb: read from an empty queue");

    // the builder stops writing at DEPTH-2, one slot always stays free
    a_wr_with_room: assert property (@(posedge clk) disable iff (rst_r)
        wr_en |-> real_occup < rb_ptr_t'(DEPTH - 1))
        else $error("prefetch_rb: write into a full queue");

endmodule

// ==== rtl/bram_simple2port.sv ====
`timescale 1ns/1ps

// simple dual-port block RAM, one write port and one read port
// read address and output are both registered, so q follows rden by two cycles
module bram_simple2port #(
    parameter int DEPTH = desc_pkg::DESC_DEPTH_DEFAULT
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] wr_addr,
    input  desc_pkg::pkt_desc_t      wr_data,
    input  logic                     wren,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    input  logic                     rden,
    output desc_pkg::pkt_desc_t      q
);
    import desc_pkg::*;

    localparam int AW = $clog2(DEPTH);

    pkt_desc_t     mem [DEPTH];
    logic [AW-1:0] rd_addr_r;  // address stage
    logic          rden_r;     // qualifies the output stage

    always_ff @(posedge clk) begin
        if (wren) begin
            mem[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        rden_r <= rden;
        if (rden) begin
            rd_addr_r <= rd_addr;
        end
        if (rden_r) begin
            q <= mem[rd_addr_r];  // output register
        end
    end

    // read-during-write on one address is undefined in the target RAM
    a_no_rw_collision: assert property (@(posedge clk)
        !(wren && rden && wr_addr == rd_addr))
        else $error("bram_simple2port: write and read to the same address");

endmodule

// ==== rtl/desc_pkg.sv ====
// shared types for the packet descriptor queue
package desc_pkg;

    // buffer address of a stored packet
    typedef logic [31:0] pkt_addr_t;

    // packet length in bytes
    typedef logic [15:0] pkt_len_t;

    // sequence number of an accepted packet, wraps around
    typedef logic [15:0] pkt_seq_t;

    // running total of dispatched bytes, wraps around
    typedef logic [31:0] byte_total_t;

    // one queue entry, 64 bits wide
    // seq sits in the top bits so a waveform reads oldest field first
    typedef struct packed {
        pkt_seq_t  seq;
        pkt_addr_t addr;
        pkt_len_t  len;
    } pkt_desc_t;

    // default queue depth, power of two and at least 16
    localparam int DESC_DEPTH_DEFAULT = 64;

endpackage
